// File: design/ctrl_pkg.sv
////////////////////////////////////////
// Widths, register map and types shared by the control block
// Register offsets are word offsets taken from adr[5:2]
////////////////////////////////////////
package ctrl_pkg;

  // qmem bus widths
  localparam int QAW = 22;
  localparam int QDW = 32;
  localparam int QSW = QDW / 8;

  // Word offsets in the register window
  typedef enum logic [3:0] {
    REG_RST       = 4'h0,
    REG_CTRL      = 4'h1,
    REG_SYS_STAT  = 4'h2,
    REG_UART_TX   = 4'h3,
    REG_UART_RX   = 4'h4,
    REG_UART_STAT = 4'h5,
    REG_TIMER     = 4'h6,
    REG_SPI_DIV   = 4'h7,
    REG_SPI_CS    = 4'h8,
    REG_SPI_DAT   = 4'h9,
    REG_SPI_BLOCK = 4'ha
  } reg_addr_e;

  // UART status nibble, msb first
  typedef struct packed {
    logic tx_ready;
    logic rx_ready;
    logic rx_miss;
    logic rx_valid;
  } uart_stat_t;

  // SPI byte engine
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    // One extra divider period after the last rising edge
    SPI_TAIL
  } spi_state_e;

endpackage

// File: design/ctrl_ifs.sv
////////////////////////////////////////
// Bus interfaces inside the control block
// All strobes are single-cycle and synchronous to clk
////////////////////////////////////////
`timescale 1ns/1ps

// qmem bus, plain cs/we level handshake
interface qmem_if import ctrl_pkg::*; ();
  logic [QAW-1:0] adr;
  logic           cs;
  logic           we;
  logic [QSW-1:0] sel;
  logic [QDW-1:0] dat_w;
  logic [QDW-1:0] dat_r;
  logic           ack;

  modport master (output adr, cs, we, sel, dat_w, input dat_r, ack);
  modport slave  (input adr, cs, we, sel, dat_w, output dat_r, ack);
endinterface

// Register block to UART
interface uart_if import ctrl_pkg::*; ();
  logic       tx_start;
  logic [7:0] tx_data;
  logic       rx_read;
  logic       stat_read;
  logic       tx_ready;
  logic [7:0] rx_data;
  uart_stat_t stat;

  modport regs   (output tx_start, tx_data, rx_read, stat_read,
                  input tx_ready, rx_data, stat);
  modport device (input tx_start, tx_data, rx_read, stat_read,
                  output tx_ready, rx_data, stat);
endinterface

// Register block to SPI engine
interface spi_if import ctrl_pkg::*; ();
  logic           div_wr;
  logic           cs_wr;
  logic           dat_wr;
  logic           block_wr;
  logic [QDW-1:0] wdata;
  logic           busy;
  logic [5:0]     div_val;
  logic [7:0]     rx_byte;

  modport regs   (output div_wr, cs_wr, dat_wr, block_wr, wdata,
                  input busy, div_val, rx_byte);
  modport device (input div_wr, cs_wr, dat_wr, block_wr, wdata,
                  output busy, div_val, rx_byte);
endinterface

// File: design/ctrl_uart.sv
////////////////////////////////////////
// 8N1 UART, TX_DIV clocks per bit, RX_DIV clocks per 1/16 bit
// No FIFOs; tx_start must only come while tx_ready is high
////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_uart import ctrl_pkg::*; #(
  parameter int TX_DIV = 434,
  parameter int RX_DIV = 27
) (
  input  logic   clk,
  input  logic   rst,
  uart_if.device ctl,
  output logic   txd,
  input  logic   rxd
);

  localparam int TW = (TX_DIV > 1) ? $clog2(TX_DIV) : 1;
  localparam int RW = (RX_DIV > 1) ? $clog2(RX_DIV) : 1;

  // Transmitter
  logic [3:0]    tx_cnt;
  logic [TW-1:0] tx_timer;
  logic [9:0]    tx_reg;
  logic          tx_ready;

  // Receiver
  logic [1:0]    rxd_sync;
  logic          rxd_bit;
  logic          rx_start;
  logic [RW-1:0] rx_div_cnt;
  logic          rx_tick;
  logic [3:0]    rx_os_cnt;
  logic          rx_sample;
  logic [3:0]    rx_bit_cnt;
  logic [9:0]    rx_recv;
  logic          rx_last;
  logic          rx_good;
  logic [7:0]    rx_data;
  logic          rx_valid;
  logic          rx_miss;

  ////////////////////////////////////////
  // Transmit
  ////////////////////////////////////////

  assign tx_ready = (tx_cnt == 4'd0) && (tx_timer == '0);

  // Bit timer and remaining bit count
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_cnt   <= 4'd0;
      tx_timer <= '0;
    end else if (ctl.tx_start) begin
      tx_cnt   <= 4'd9;
      tx_timer <= TW'(TX_DIV - 1);
    end else if (tx_timer != '0) begin
      tx_timer <= tx_timer - 1'b1;
    end else if (tx_cnt != 4'd0) begin
      tx_cnt   <= tx_cnt - 4'd1;
      tx_timer <= TW'(TX_DIV - 1);
    end
  end

  // Stop, data lsb first, start; ones shift in behind
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_reg <= '1;
    end else if (ctl.tx_start) begin
      tx_reg <= {1'b1, ctl.tx_data, 1'b0};
    end else if (tx_timer == '0) begin
      tx_reg <= {1'b1, tx_reg[9:1]};
    end
  end

  assign txd = tx_reg[0];

  ////////////////////////////////////////
  // Receive
  ////////////////////////////////////////

  // Two-flop sync plus one delay for edge detect
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rxd_sync <= 2'b11;
      rxd_bit  <= 1'b1;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
      rxd_bit  <= rxd_sync[1];
    end
  end

  // Falling edge while idle starts a frame
  assign rx_start  = rxd_bit && !rxd_sync[1] && (rx_bit_cnt == 4'd0);
  assign rx_tick   = (rx_div_cnt == '0);
  // Middle of each bit, 1/16 position 8
  assign rx_sample = rx_tick && (rx_os_cnt == 4'd8) && (rx_bit_cnt != 4'd0);
  assign rx_good   = rx_last && rx_recv[9];

  // 1/16 bit divider
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_div_cnt <= RW'(RX_DIV - 1);
    end else if (rx_start || rx_tick) begin
      rx_div_cnt <= RW'(RX_DIV - 1);
    end else if (rx_bit_cnt != 4'd0) begin
      rx_div_cnt <= rx_div_cnt - 1'b1;
    end
  end

  // Oversample phase
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_os_cnt <= 4'hf;
    end else if (rx_start) begin
      rx_os_cnt <= 4'hf;
    end else if (rx_tick) begin
      rx_os_cnt <= rx_os_cnt - 4'd1;
    end
  end

  // Start, 8 data, stop
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_bit_cnt <= 4'd0;
      rx_last    <= 1'b0;
    end else begin
      rx_last <= rx_sample && (rx_bit_cnt == 4'd1);
      if (rx_start) begin
        rx_bit_cnt <= 4'd10;
      end else if (rx_sample) begin
        rx_bit_cnt <= rx_bit_cnt - 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_sample) begin
      rx_recv <= {rxd_bit, rx_recv[9:1]};
    end
    // Keep the byte only when framed by a high stop bit
    if (rx_good) begin
      rx_data <= rx_recv[8:1];
    end
  end

  // Valid until the data register is read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_valid <= 1'b0;
    end else if (rx_good) begin
      rx_valid <= 1'b1;
    end else if (ctl.rx_read) begin
      rx_valid <= 1'b0;
    end
  end

  // Overrun, cleared by a status read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_miss <= 1'b0;
    end else if (rx_good && rx_valid) begin
      rx_miss <= 1'b1;
    end else if (ctl.stat_read) begin
      rx_miss <= 1'b0;
    end
  end

  assign ctl.tx_ready = tx_ready;
  assign ctl.rx_data  = rx_data;
  assign ctl.stat     = '{tx_ready: tx_ready,
                          rx_ready: (rx_bit_cnt == 4'd0),
                          rx_miss:  rx_miss,
                          rx_valid: rx_valid};

endmodule

// File: design/ctrl_spi.sv
////////////////////////////////////////
// SPI master, mode 3, msb first; each half period is div+1 clocks
// Writes other than cs must only arrive while idle
////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_spi import ctrl_pkg::*; #(
  parameter int SPI_DIV_RST = 62
) (
  input  logic       clk,
  input  logic       rst,
  spi_if.device      ctl,
  output logic [3:0] cs_n,
  output logic       sclk,
  output logic       mosi,
  input  logic       miso
);

  spi_state_e state;
  logic [5:0] div_r;
  logic [5:0] div_cnt;
  // Odd values are clock high, 15 is idle
  logic [3:0] edge_cnt;
  logic [9:0] block;
  logic [7:0] sh_out;
  logic [7:0] sh_in;
  logic       first_byte;
  logic       step;
  logic [3:0] cs_mask;
  logic [3:0] cs_val;

  // One half period elapsed
  assign step    = (state == SPI_SHIFT) && (div_cnt == 6'd0);
  assign cs_mask = ctl.wdata[7:4];
  assign cs_val  = ctl.wdata[3:0];

  // Chip selects, active low
  // Nonzero mask touches only the masked bits
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cs_n <= 4'b1111;
    end else if (ctl.cs_wr) begin
      if (cs_mask != 4'd0) begin
        cs_n <= (cs_mask & ~cs_val) | (~cs_mask & cs_n);
      end else begin
        cs_n <= ~cs_val;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      div_r <= 6'(SPI_DIV_RST);
    end else if (ctl.div_wr) begin
      div_r <= ctl.wdata[5:0];
    end
  end

  ////////////////////////////////////////
  // Byte engine
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= SPI_IDLE;
      div_cnt    <= 6'd0;
      edge_cnt   <= 4'hf;
      block      <= 10'd0;
      first_byte <= 1'b0;
    end else begin
      if (ctl.block_wr) begin
        block <= ctl.wdata[9:0];
      end
      case (state)
        SPI_IDLE: begin
          if (ctl.dat_wr) begin
            state      <= SPI_SHIFT;
            div_cnt    <= div_r;
            first_byte <= 1'b1;
          end
        end
        SPI_SHIFT: begin
          if (div_cnt != 6'd0) begin
            div_cnt <= div_cnt - 6'd1;
          end else begin
            div_cnt    <= div_r;
            edge_cnt   <= edge_cnt - 4'd1;
            first_byte <= 1'b0;
            // Last rising edge of a byte, chain or finish
            if (edge_cnt == 4'd0) begin
              if (block != 10'd0) begin
                block <= block - 10'd1;
              end else begin
                state <= SPI_TAIL;
              end
            end
          end
        end
        SPI_TAIL: begin
          if (div_cnt != 6'd0) begin
            div_cnt <= div_cnt - 6'd1;
          end else begin
            state <= SPI_IDLE;
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  // Out on falling edges; msb already present before the first one
  // Chained bytes shift in ones, so they send 0xff
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sh_out <= 8'hff;
    end else if (ctl.dat_wr) begin
      sh_out <= ctl.wdata[7:0];
    end else if (step && edge_cnt[0] && !first_byte) begin
      sh_out <= {sh_out[6:0], 1'b1};
    end
  end

  // In on rising edges
  always_ff @(posedge clk) begin
    if (step && !edge_cnt[0]) begin
      sh_in <= {sh_in[6:0], miso};
    end
  end

  assign sclk        = edge_cnt[0];
  assign mosi        = sh_out[7];
  assign ctl.busy    = (state != SPI_IDLE);
  assign ctl.div_val = div_r;
  assign ctl.rx_byte = sh_in;

endmodule

// File: design/ctrl_regs.sv
////////////////////////////////////////
// qmem register block; ack is combinational on adr, sel is ignored
// Read data is captured at the accepted edge, unmapped offsets read 0
////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_regs import ctrl_pkg::*; #(
  parameter int TX_DIV      = 434,
  parameter int RX_DIV      = 27,
  parameter int TIMER_DIV   = 50000,
  parameter int SPI_DIV_RST = 62
) (
  input  logic       clk,
  input  logic       rst,
  qmem_if.slave      bus,
  input  logic [3:0] ctrl_cfg,
  input  logic [3:0] sys_status,
  output logic       sys_rst,
  output logic       core_rst,
  output logic       cpu_rst,
  output logic [3:0] ctrl_status,
  output logic       uart_txd,
  input  logic       uart_rxd,
  output logic [3:0] spi_cs_n,
  output logic       spi_clk,
  output logic       spi_do,
  input  logic       spi_di
);

  // Prescaler width, holds TIMER_DIV-1
  localparam int PW = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

  uart_if uart_bus ();
  spi_if  spi_bus ();

  reg_addr_e      off;
  logic           acc;
  logic           wr_acc;
  logic           wr_rst;
  logic           wr_ctrl;
  logic           wr_timer;
  logic [QDW-1:0] rd_data;
  logic [PW-1:0]  pre_timer;
  logic [15:0]    timer;

  ////////////////////////////////////////
  // Decode and strobes
  ////////////////////////////////////////

  assign off    = reg_addr_e'(bus.adr[5:2]);
  // Accepted cycle
  assign acc    = bus.cs && bus.ack;
  assign wr_acc = acc && bus.we;

  assign wr_rst   = wr_acc && (off == REG_RST);
  assign wr_ctrl  = wr_acc && (off == REG_CTRL);
  assign wr_timer = wr_acc && (off == REG_TIMER);

  // UART side
  assign uart_bus.tx_start  = wr_acc && (off == REG_UART_TX);
  assign uart_bus.tx_data   = bus.dat_w[7:0];
  // Read side effects fire on any accepted access
  assign uart_bus.rx_read   = acc && (off == REG_UART_RX);
  assign uart_bus.stat_read = acc && (off == REG_UART_STAT);

  // SPI side
  assign spi_bus.div_wr   = wr_acc && (off == REG_SPI_DIV);
  assign spi_bus.cs_wr    = wr_acc && (off == REG_SPI_CS);
  assign spi_bus.dat_wr   = wr_acc && (off == REG_SPI_DAT);
  assign spi_bus.block_wr = wr_acc && (off == REG_SPI_BLOCK);
  assign spi_bus.wdata    = bus.dat_w;

  // Hold off TX while framing, SPI while engine runs
  always_comb begin
    case (off)
      REG_UART_TX:   bus.ack = uart_bus.tx_ready;
      REG_SPI_DIV,
      REG_SPI_CS,
      REG_SPI_DAT,
      REG_SPI_BLOCK: bus.ack = !spi_bus.busy;
      default:       bus.ack = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // Reset and control registers
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sys_rst  <= 1'b0;
      core_rst <= 1'b0;
      cpu_rst  <= 1'b0;
    end else if (wr_rst) begin
      sys_rst  <= bus.dat_w[0];
      core_rst <= bus.dat_w[1];
      cpu_rst  <= bus.dat_w[2];
    end
  end

  // Status leds in bits 19:16
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl_status <= 4'd0;
    end else if (wr_ctrl) begin
      ctrl_status <= bus.dat_w[19:16];
    end
  end

  ////////////////////////////////////////
  // Timer
  ////////////////////////////////////////

  // Write loads both counter and prescaler
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pre_timer <= PW'(TIMER_DIV - 1);
      timer     <= 16'd0;
    end else if (wr_timer) begin
      pre_timer <= PW'(TIMER_DIV - 1);
      timer     <= bus.dat_w[15:0];
    end else if (pre_timer == '0) begin
      // One tick per TIMER_DIV clocks
      pre_timer <= PW'(TIMER_DIV - 1);
      timer     <= timer + 16'd1;
    end else begin
      pre_timer <= pre_timer - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  always_comb begin
    case (off)
      REG_CTRL:      rd_data = {28'd0, ctrl_cfg};
      REG_SYS_STAT:  rd_data = {28'd0, sys_status};
      REG_UART_RX:   rd_data = {24'd0, uart_bus.rx_data};
      REG_UART_STAT: rd_data = {28'd0, uart_bus.stat};
      REG_TIMER:     rd_data = {16'd0, timer};
      REG_SPI_DIV:   rd_data = {26'd0, spi_bus.div_val};
      REG_SPI_DAT:   rd_data = {24'd0, spi_bus.rx_byte};
      default:       rd_data = '0;
    endcase
  end

  // Status is captured before its clear takes effect
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus.dat_r <= '0;
    end else if (acc) begin
      bus.dat_r <= rd_data;
    end
  end

  ////////////////////////////////////////
  // Peripherals
  ////////////////////////////////////////

  ctrl_uart #(
    .TX_DIV (TX_DIV),
    .RX_DIV (RX_DIV)
  ) uart_i (
    .clk (clk),
    .rst (rst),
    .ctl (uart_bus.device),
    .txd (uart_txd),
    .rxd (uart_rxd)
  );

  ctrl_spi #(
    .SPI_DIV_RST (SPI_DIV_RST)
  ) spi_i (
    .clk  (clk),
    .rst  (rst),
    .ctl  (spi_bus.device),
    .cs_n (spi_cs_n),
    .sclk (spi_clk),
    .mosi (spi_do),
    .miso (spi_di)
  );

endmodule

// File: design/ctrl_top.sv
////////////////////////////////////////
// Control block top with plain qmem ports
// Timing parameters are in clock cycles
////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_top import ctrl_pkg::*; #(
  parameter int TX_DIV      = 434,
  parameter int RX_DIV      = 27,
  parameter int TIMER_DIV   = 50000,
  parameter int SPI_DIV_RST = 62
) (
  input  logic           clk,
  input  logic           rst,
  input  logic [QAW-1:0] adr,
  input  logic           cs,
  input  logic           we,
  input  logic [QSW-1:0] sel,
  input  logic [QDW-1:0] dat_w,
  output logic [QDW-1:0] dat_r,
  output logic           ack,
  input  logic [3:0]     ctrl_cfg,
  input  logic [3:0]     sys_status,
  output logic           sys_rst,
  output logic           core_rst,
  output logic           cpu_rst,
  output logic [3:0]     ctrl_status,
  output logic           uart_txd,
  input  logic           uart_rxd,
  output logic [3:0]     spi_cs_n,
  output logic           spi_clk,
  output logic           spi_do,
  input  logic           spi_di
);

  qmem_if bus_i ();

  // Plain ports onto the bus interface
  assign bus_i.adr   = adr;
  assign bus_i.cs    = cs;
  assign bus_i.we    = we;
  assign bus_i.sel   = sel;
  assign bus_i.dat_w = dat_w;
  assign dat_r       = bus_i.dat_r;
  assign ack         = bus_i.ack;

  ctrl_regs #(
    .TX_DIV      (TX_DIV),
    .RX_DIV      (RX_DIV),
    .TIMER_DIV   (TIMER_DIV),
    .SPI_DIV_RST (SPI_DIV_RST)
  ) regs_i (
    .clk         (clk),
    .rst         (rst),
    .bus         (bus_i.slave),
    .ctrl_cfg    (ctrl_cfg),
    .sys_status  (sys_status),
    .sys_rst     (sys_rst),
    .core_rst    (core_rst),
    .cpu_rst     (cpu_rst),
    .ctrl_status (ctrl_status),
    .uart_txd    (uart_txd),
    .uart_rxd    (uart_rxd),
    .spi_cs_n    (spi_cs_n),
    .spi_clk     (spi_clk),
    .spi_do      (spi_do),
    .spi_di      (spi_di)
  );

endmodule

// File: verification/ctrl_sva.sv
////////////////////////////////////////
// Concurrent checks on the register block, attached by bind
// Disabled while rst is high
////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_sva import ctrl_pkg::*; (
  input logic       clk,
  input logic       rst,
  input spi_state_e spi_state,
  input logic       spi_busy,
  input logic       spi_clk,
  input logic       uart_txd,
  input logic       tx_ready,
  input logic       ack,
  input logic [3:0] off,
  input logic       cs_wr,
  input logic [3:0] spi_cs_n
);

  // Idle engine parks the clock high
  idle_clk_high: assert property (@(posedge clk) disable iff (rst)
    (spi_state == SPI_IDLE) |-> (spi_clk && !spi_busy))
    else $error("SPI idle with clock low or busy set");

  // Line stays at mark level between frames
  tx_idle_mark: assert property (@(posedge clk) disable iff (rst)
    tx_ready |-> uart_txd)
    else $error("uart_txd low while transmitter ready");

  // SPI registers held off while shifting
  spi_ack_hold: assert property (@(posedge clk) disable iff (rst)
    (spi_busy && (off inside {REG_SPI_DIV, REG_SPI_CS, REG_SPI_DAT, REG_SPI_BLOCK}))
    |-> !ack)
    else $error("ack given for SPI register while engine busy");

  // Chip selects move only on a cs write
  cs_write_only: assert property (@(posedge clk) disable iff (rst)
    !$stable(spi_cs_n) |-> $past(cs_wr))
    else $error("spi_cs_n changed without a cs write");

endmodule

bind ctrl_regs ctrl_sva sva_i (
  .clk       (clk),
  .rst       (rst),
  .spi_state (spi_i.state),
  .spi_busy  (spi_bus.busy),
  .spi_clk   (spi_clk),
  .uart_txd  (uart_txd),
  .tx_ready  (uart_bus.tx_ready),
  .ack       (bus.ack),
  .off       (bus.adr[5:2]),
  .cs_wr     (spi_bus.cs_wr),
  .spi_cs_n  (spi_cs_n)
);

// File: verification/ctrl_tb.sv
////////////////////////////////////////
// Directed testbench for the control block, short timing parameters
// Inputs change on falling clk, bus requests held until ack
////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_tb import ctrl_pkg::*; ();

  localparam int TX_DIV      = 16;
  localparam int RX_DIV      = 1;
  localparam int TIMER_DIV   = 40;
  localparam int SPI_DIV_RST = 3;

  // Run length budget in clock cycles
  localparam int BIT_CYC   = 16 * RX_DIV;
  localparam int FRAME_CYC = 10 * TX_DIV;
  localparam int XFER_CYC  = 17 * (SPI_DIV_RST + 1);
  localparam int N_FRAMES  = 8;
  localparam int N_TICKS   = 8;
  localparam int N_BYTES   = 5;
  localparam int LIMIT     = 2 * (N_FRAMES * FRAME_CYC + N_TICKS * TIMER_DIV
                                  + N_BYTES * XFER_CYC) + 200;

  // Status nibbles, tx_ready rx_ready rx_miss rx_valid
  localparam uart_stat_t STAT_IDLE  = '{1'b1, 1'b1, 1'b0, 1'b0};
  localparam uart_stat_t STAT_TXBSY = '{1'b0, 1'b1, 1'b0, 1'b0};
  localparam uart_stat_t STAT_VALID = '{1'b1, 1'b1, 1'b0, 1'b1};
  localparam uart_stat_t STAT_MISS  = '{1'b1, 1'b1, 1'b1, 1'b1};
  localparam uart_stat_t MASK_VALID = '{1'b0, 1'b0, 1'b0, 1'b1};
  localparam uart_stat_t MASK_MISS  = '{1'b0, 1'b0, 1'b1, 1'b0};

  logic           clk;
  logic           rst;
  logic [QAW-1:0] adr;
  logic           cs;
  logic           we;
  logic [QSW-1:0] sel;
  logic [QDW-1:0] dat_w;
  logic [QDW-1:0] dat_r;
  logic           ack;
  logic [3:0]     ctrl_cfg;
  logic [3:0]     sys_status;
  logic           sys_rst;
  logic           core_rst;
  logic           cpu_rst;
  logic [3:0]     ctrl_status;
  logic           uart_txd;
  logic           uart_rxd;
  logic [3:0]     spi_cs_n;
  logic           spi_clk;
  logic           spi_do;
  logic           spi_di;

  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          failed = 0;
  logic [31:0] rng = 32'd44;
  // SPI slave model state
  logic [7:0]  slave_tx = 8'hff;
  logic [31:0] slave_rx = '0;
  int          spi_rises = 0;

  ctrl_top #(
    .TX_DIV      (TX_DIV),
    .RX_DIV      (RX_DIV),
    .TIMER_DIV   (TIMER_DIV),
    .SPI_DIV_RST (SPI_DIV_RST)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .adr         (adr),
    .cs          (cs),
    .we          (we),
    .sel         (sel),
    .dat_w       (dat_w),
    .dat_r       (dat_r),
    .ack         (ack),
    .ctrl_cfg    (ctrl_cfg),
    .sys_status  (sys_status),
    .sys_rst     (sys_rst),
    .core_rst    (core_rst),
    .cpu_rst     (cpu_rst),
    .ctrl_status (ctrl_status),
    .uart_txd    (uart_txd),
    .uart_rxd    (uart_rxd),
    .spi_cs_n    (spi_cs_n),
    .spi_clk     (spi_clk),
    .spi_do      (spi_do),
    .spi_di      (spi_di)
  );

  // 4 ns period
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////
  // Helpers and compares
  ////////////////////////////////////////

  function automatic logic [31:0] rand_next();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic cmp_word(input string what, input logic [QDW-1:0] got,
                          input logic [QDW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic cmp_stat(input string what, input uart_stat_t got, input uart_stat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic cmp_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    tests++;
    if (errors == err_start) begin
      $display("[%0t] %s passed", $time, name);
    end else begin
      failed++;
      $display("[%0t] %s failed with %0d errors", $time, name, errors - err_start);
    end
  endtask

  ////////////////////////////////////////
  // Bus master
  ////////////////////////////////////////

  // Accepted at the rising edge after ack is seen high
  task automatic bus_write(input logic [3:0] off, input logic [QDW-1:0] data);
    @(negedge clk);
    adr   = QAW'({off, 2'b00});
    cs    = 1'b1;
    we    = 1'b1;
    dat_w = data;
    #1;
    while (ack !== 1'b1) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  // Data valid in the cycle after acceptance
  task automatic bus_read(input logic [3:0] off, output logic [QDW-1:0] data);
    @(negedge clk);
    adr = QAW'({off, 2'b00});
    cs  = 1'b1;
    we  = 1'b0;
    #1;
    while (ack !== 1'b1) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    data = dat_r;
    cs   = 1'b0;
  endtask

  ////////////////////////////////////////
  // Serial models
  ////////////////////////////////////////

  // Start, 8 data lsb first, stop, BIT_CYC cycles each
  task automatic uart_send(input logic [7:0] data, input logic stop);
    logic [9:0] bits;
    bits = {stop, data, 1'b0};
    @(negedge clk);
    for (int i = 0; i < 10; i++) begin
      uart_rxd = bits[i];
      repeat (BIT_CYC) @(negedge clk);
    end
    uart_rxd = 1'b1;
  endtask

  // Find the start bit, then sample mid bit
  task automatic uart_decode(output logic [7:0] data);
    int waited;
    waited = 0;
    data   = 'x;
    do begin
      @(negedge clk);
      waited++;
    end while (uart_txd !== 1'b0 && waited < 2 * FRAME_CYC);
    if (uart_txd !== 1'b0) begin
      errors++;
      $display("No start bit seen on uart_txd");
    end else begin
      repeat (TX_DIV / 2) @(negedge clk);
      cmp_word("tx start bit", uart_txd, 32'd0);
      for (int i = 0; i < 8; i++) begin
        repeat (TX_DIV) @(negedge clk);
        data[i] = uart_txd;
      end
      repeat (TX_DIV) @(negedge clk);
      cmp_word("tx stop bit", uart_txd, 32'd1);
    end
  endtask

  // Poll status until a flag in mask shows up
  task automatic wait_uart_flag(input uart_stat_t mask, output uart_stat_t st);
    logic [QDW-1:0] w;
    int             tries;
    tries = 0;
    do begin
      bus_read(REG_UART_STAT, w);
      st = uart_stat_t'(w[3:0]);
      tries++;
    end while (((w[3:0] & mask) == 4'd0) && tries < 4 * BIT_CYC);
    if ((w[3:0] & mask) == 4'd0) begin
      errors++;
      $display("UART status flag %b never came up", mask);
    end
  endtask

  // Slave shifts out on falling sclk, ones after its byte
  always begin
    @(negedge spi_clk);
    @(negedge clk);
    spi_di   = slave_tx[7];
    slave_tx = {slave_tx[6:0], 1'b1};
  end

  // Master data recorded on rising sclk
  always begin
    @(posedge spi_clk);
    @(negedge clk);
    slave_rx  = {slave_rx[30:0], spi_do};
    spi_rises = spi_rises + 1;
  end

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic check_reset();
    int             e0;
    logic [QDW-1:0] w;
    e0 = errors;
    bus_read(REG_TIMER, w);
    cmp_word("timer after reset", w, 32'd0);
    cmp_word("reset outputs", {cpu_rst, core_rst, sys_rst}, 32'd0);
    cmp_word("ctrl_status", ctrl_status, 32'd0);
    cmp_word("spi_cs_n", spi_cs_n, 32'hf);
    cmp_word("spi_clk", spi_clk, 32'd1);
    cmp_word("uart_txd", uart_txd, 32'd1);
    bus_read(REG_SPI_DIV, w);
    cmp_word("spi divider", w, SPI_DIV_RST);
    bus_read(REG_UART_STAT, w);
    cmp_stat("uart status", uart_stat_t'(w[3:0]), STAT_IDLE);
    end_test("reset values", e0);
  endtask

  task automatic check_registers();
    int             e0;
    logic [QDW-1:0] w;
    logic [QDW-1:0] r;
    e0 = errors;
    bus_write(REG_RST, 32'h5);
    cmp_word("reset pins", {cpu_rst, core_rst, sys_rst}, 32'h5);
    bus_write(REG_RST, 32'h2);
    cmp_word("reset pins", {cpu_rst, core_rst, sys_rst}, 32'h2);
    r = rand_next();
    bus_write(REG_CTRL, r);
    cmp_word("ctrl_status", ctrl_status, r[19:16]);
    // Inputs change on the falling edge
    @(negedge clk);
    ctrl_cfg   = 4'ha;
    sys_status = 4'h6;
    bus_read(REG_CTRL, w);
    cmp_word("ctrl_cfg read", w, 32'ha);
    bus_read(REG_SYS_STAT, w);
    cmp_word("sys_status read", w, 32'h6);
    bus_write(REG_SPI_DIV, 32'd1);
    bus_read(REG_SPI_DIV, w);
    cmp_word("spi divider", w, 32'd1);
    bus_read(4'hc, w);
    cmp_word("unmapped read", w, 32'd0);
    end_test("register access", e0);
  endtask

  task automatic check_uart_tx();
    int             e0;
    int             t0;
    int             t1;
    logic [7:0]     b0;
    logic [7:0]     b1;
    logic [7:0]     got0;
    logic [7:0]     got1;
    logic [QDW-1:0] w;
    e0 = errors;
    b0 = 8'(rand_next());
    b1 = 8'(rand_next());
    bus_write(REG_UART_TX, {24'd0, b0});
    t0 = cycle;
    fork
      uart_decode(got0);
      begin
        bus_read(REG_UART_STAT, w);
        cmp_stat("status in frame", uart_stat_t'(w[3:0]), STAT_TXBSY);
        // Held off by ack until the frame is out
        bus_write(REG_UART_TX, {24'd0, b1});
        t1 = cycle;
      end
    join
    uart_decode(got1);
    cmp_byte("first tx byte", got0, b0);
    cmp_byte("second tx byte", got1, b1);
    cmp_word("cycles between tx writes", t1 - t0, FRAME_CYC);
    end_test("uart transmit", e0);
  endtask

  task automatic check_uart_rx();
    int             e0;
    logic [7:0]     b0;
    logic [7:0]     b1;
    logic [7:0]     b2;
    logic [QDW-1:0] w;
    uart_stat_t     st;
    e0 = errors;
    b0 = 8'(rand_next());
    b1 = 8'(rand_next());
    b2 = 8'(rand_next());
    // Single frame
    uart_send(b0, 1'b1);
    wait_uart_flag(MASK_VALID, st);
    cmp_stat("status after frame", st, STAT_VALID);
    bus_read(REG_UART_RX, w);
    cmp_word("rx data", w, {24'd0, b0});
    bus_read(REG_UART_STAT, w);
    cmp_stat("status after data read", uart_stat_t'(w[3:0]), STAT_IDLE);
    // Overrun on the unread frame
    uart_send(b1, 1'b1);
    wait_uart_flag(MASK_VALID, st);
    uart_send(b2, 1'b1);
    wait_uart_flag(MASK_MISS, st);
    cmp_stat("status on overrun", st, STAT_MISS);
    bus_read(REG_UART_STAT, w);
    cmp_stat("status after miss clear", uart_stat_t'(w[3:0]), STAT_VALID);
    bus_read(REG_UART_RX, w);
    cmp_word("rx data after overrun", w, {24'd0, b2});
    bus_read(REG_UART_STAT, w);
    cmp_stat("status after data read", uart_stat_t'(w[3:0]), STAT_IDLE);
    // Framing error drops the byte
    uart_send(8'(rand_next()), 1'b0);
    repeat (2 * BIT_CYC) @(negedge clk);
    bus_read(REG_UART_STAT, w);
    cmp_stat("status after bad stop", uart_stat_t'(w[3:0]), STAT_IDLE);
    end_test("uart receive", e0);
  endtask

  task automatic check_timer();
    int             e0;
    logic [15:0]    start;
    logic [QDW-1:0] w;
    e0 = errors;
    for (int k = 1; k <= 3; k++) begin
      start = 16'(rand_next()) & 16'h0fff;
      bus_write(REG_TIMER, {16'd0, start});
      // Middle of the k-th tick window
      repeat (k * TIMER_DIV + TIMER_DIV / 2) @(negedge clk);
      bus_read(REG_TIMER, w);
      cmp_word("timer value", w, start + k);
    end
    end_test("timer", e0);
  endtask

  task automatic check_spi();
    int             e0;
    logic [7:0]     mb;
    logic [7:0]     sb;
    logic [QDW-1:0] w;
    e0 = errors;
    // Chip select writes, mask in bits 7:4
    bus_write(REG_SPI_CS, 32'h05);
    cmp_word("cs_n after 0x05", spi_cs_n, 32'ha);
    bus_write(REG_SPI_CS, 32'h8b);
    cmp_word("cs_n after 0x8b", spi_cs_n, 32'h2);
    bus_write(REG_SPI_CS, 32'h10);
    cmp_word("cs_n after 0x10", spi_cs_n, 32'h3);
    bus_write(REG_SPI_CS, 32'h00);
    cmp_word("cs_n after 0x00", spi_cs_n, 32'hf);
    // Single byte, read waits on busy through ack
    mb        = 8'(rand_next());
    sb        = 8'(rand_next());
    slave_tx  = sb;
    slave_rx  = '0;
    spi_rises = 0;
    bus_write(REG_SPI_DAT, {24'd0, mb});
    bus_read(REG_SPI_DAT, w);
    cmp_word("spi rx byte", w, {24'd0, sb});
    cmp_byte("byte seen by slave", slave_rx[7:0], mb);
    cmp_word("rising edges", spi_rises, 32'd8);
    // Block of three bytes
    mb        = 8'(rand_next());
    slave_tx  = 8'(rand_next());
    slave_rx  = '0;
    spi_rises = 0;
    bus_write(REG_SPI_BLOCK, 32'd2);
    bus_write(REG_SPI_DAT, {24'd0, mb});
    bus_read(REG_SPI_DAT, w);
    cmp_word("block rising edges", spi_rises, 32'd24);
    cmp_byte("block first byte", slave_rx[23:16], mb);
    cmp_byte("block second byte", slave_rx[15:8], 8'hff);
    cmp_byte("block third byte", slave_rx[7:0], 8'hff);
    cmp_word("block last rx byte", w, 32'hff);
    end_test("spi transfer", e0);
  endtask

  ////////////////////////////////////////
  // Sequence and end of run
  ////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    adr        = '0;
    cs         = 1'b0;
    we         = 1'b0;
    sel        = '1;
    dat_w      = '0;
    ctrl_cfg   = 4'h3;
    sys_status = 4'h9;
    uart_rxd   = 1'b1;
    spi_di     = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    check_reset();
    check_registers();
    check_uart_tx();
    check_uart_rx();
    check_timer();
    check_spi();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (cycle >= LIMIT);
    $display("Timeout: run stopped after %0d cycles", LIMIT);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: ctrl_regs.f
design/ctrl_pkg.sv
design/ctrl_ifs.sv
design/ctrl_uart.sv
design/ctrl_spi.sv
design/ctrl_regs.sv
design/ctrl_top.sv
verification/ctrl_sva.sv
verification/ctrl_tb.sv
